//--- design/elastic_buffer.sv
`timescale 1ns/1ps
//**************************************************************************
// Elastic buffer
// Small valid/ready FIFO with a registered occupancy count. Takes a new
// beat while not full, or while full if the head leaves in that cycle
//**************************************************************************
module elastic_buffer #(
    parameter int  depth  = 2,
    parameter type data_t = logic
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  in_valid,
    output logic  in_ready,
    input  data_t in_data,
    output logic  out_valid,
    input  logic  out_ready,
    output data_t out_data
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    data_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign out_valid = (count != '0);
    assign in_ready  = (count != cnt_w'(depth)) || out_ready;
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

//--- design/gpr_file.sv
`timescale 1ns/1ps
//**************************************************************************
// General-purpose register file
// One bank per warp, one word per thread, written under the writeback
// thread mask. Single read port with a registered output
//**************************************************************************
module gpr_file (
    input  logic                clk,
    input  logic                wb_valid,
    input  opc_pkg::writeback_t wb,
    input  opc_pkg::wid_t       rd_wid,
    input  opc_pkg::reg_id_t    rd_reg,
    output opc_pkg::lane_data_t rd_data
);
    import opc_pkg::*;

    localparam int entries = num_warps * num_regs;
    localparam int addr_w  = $bits(wid_t) + $bits(reg_id_t);

    lane_data_t        mem [entries];
    logic [addr_w-1:0] wr_addr;
    logic [addr_w-1:0] rd_addr;

    // Warp number selects the bank in the upper address bits
    assign wr_addr = {wb.wid, wb.rd};
    assign rd_addr = {rd_wid, rd_reg};

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            for (int t = 0; t < num_threads; t++) begin
                if (wb.tmask[t]) begin
                    mem[wr_addr][t] <= wb.data[t];
                end
            end
        end
    end

    // A write to the same entry in this cycle is not seen until the next read
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- design/opc_pkg.sv
//**************************************************************************
// Operand collection stage, shared definitions
// Widths and counts of the core, the vector types for warps, registers
// and lanes, the fetch FSM states and the payloads of the issue,
// staging, output and writeback streams
//**************************************************************************
package opc_pkg;

    localparam int num_warps   = 4;
    localparam int num_threads = 4;
    localparam int num_regs    = 32;
    localparam int xlen        = 32;
    localparam int uuid_w      = 8;

    typedef logic [xlen-1:0]                word_t;
    typedef logic [$clog2(num_regs)-1:0]    reg_id_t;
    typedef logic [$clog2(num_warps)-1:0]   wid_t;
    typedef logic [num_threads-1:0]         tmask_t;
    typedef logic [uuid_w-1:0]              uuid_t;
    typedef logic [5:0]                     op_t;
    typedef word_t [num_threads-1:0]        lane_data_t;

    typedef enum logic [1:0] {
        idle,
        fetch_rs1,
        fetch_rs2,
        fetch_rs3
    } fetch_state_e;

    // Decoded instruction as it leaves the scoreboard
    typedef struct packed {
        uuid_t   uuid;
        wid_t    wid;
        tmask_t  tmask;
        word_t   pc;
        op_t     op;
        word_t   imm;
        reg_id_t rd;
        logic    wb;
        reg_id_t rs1;
        reg_id_t rs2;
        reg_id_t rs3;
    } issue_t;

    // Fields carried past the register read, source numbers are no longer needed
    typedef struct packed {
        uuid_t   uuid;
        wid_t    wid;
        tmask_t  tmask;
        word_t   pc;
        op_t     op;
        word_t   imm;
        reg_id_t rd;
        logic    wb;
    } stage_t;

    typedef struct packed {
        stage_t     instr;
        lane_data_t rs1_data;
        lane_data_t rs2_data;
        lane_data_t rs3_data;
    } operands_t;

    typedef struct packed {
        wid_t       wid;
        reg_id_t    rd;
        tmask_t     tmask;
        lane_data_t data;
    } writeback_t;

endpackage

//--- design/opc_top.sv
`timescale 1ns/1ps
//**************************************************************************
// Operand collection stage
// Staging buffer, operand collector, register file and output buffer
// between the issue stream and the operand stream
//**************************************************************************
module opc_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                issue_valid,
    output logic                issue_ready,
    input  opc_pkg::issue_t     issue,
    input  logic                wb_valid,
    input  opc_pkg::writeback_t wb,
    output logic                out_valid,
    input  logic                out_ready,
    output opc_pkg::operands_t  out
);
    import opc_pkg::*;

    logic       issue_fire;
    stage_t     stg_in;
    stage_t     stg_out;
    logic       stg_valid;
    logic       stg_ready;
    operands_t  col_out;
    logic       col_valid;
    logic       col_ready;
    wid_t       rd_wid;
    reg_id_t    rd_reg;
    lane_data_t rd_data;

    assign issue_fire = issue_valid && issue_ready;

    // Source numbers stay with the collector, the rest waits in staging
    assign stg_in = '{uuid: issue.uuid, wid: issue.wid, tmask: issue.tmask, pc: issue.pc,
                      op: issue.op, imm: issue.imm, rd: issue.rd, wb: issue.wb};

    gpr_file gpr (
        .clk      (clk),
        .wb_valid (wb_valid),
        .wb       (wb),
        .rd_wid   (rd_wid),
        .rd_reg   (rd_reg),
        .rd_data  (rd_data)
    );

    elastic_buffer #(.depth(2), .data_t(stage_t)) stg_buf (
        .clk       (clk),
        .reset     (reset || flush),
        .in_valid  (issue_valid),
        .in_ready  (issue_ready),
        .in_data   (stg_in),
        .out_valid (stg_valid),
        .out_ready (stg_ready),
        .out_data  (stg_out)
    );

    operand_collector collector (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .issue_fire (issue_fire),
        .issue      (issue),
        .rd_wid     (rd_wid),
        .rd_reg     (rd_reg),
        .rd_data    (rd_data),
        .stg_valid  (stg_valid),
        .stg_ready  (stg_ready),
        .stg        (stg_out),
        .out_valid  (col_valid),
        .out_ready  (col_ready),
        .out        (col_out)
    );

    elastic_buffer #(.depth(2), .data_t(operands_t)) out_buf (
        .clk       (clk),
        .reset     (reset || flush),
        .in_valid  (col_valid),
        .in_ready  (col_ready),
        .in_data   (col_out),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out)
    );

endmodule

//--- design/operand_collector.sv
`timescale 1ns/1ps
//**************************************************************************
// Operand collector
// Reads the non-zero sources of one instruction at a time through the
// single register file port, then releases the staged instruction
// together with its three operand vectors to the output buffer
//**************************************************************************
module operand_collector (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                issue_fire,
    input  opc_pkg::issue_t     issue,
    output opc_pkg::wid_t       rd_wid,
    output opc_pkg::reg_id_t    rd_reg,
    input  opc_pkg::lane_data_t rd_data,
    input  logic                stg_valid,
    output logic                stg_ready,
    input  opc_pkg::stage_t     stg,
    output logic                out_valid,
    input  logic                out_ready,
    output opc_pkg::operands_t  out
);
    import opc_pkg::*;

    fetch_state_e state, state_n;
    wid_t         cur_wid, cur_wid_n;
    reg_id_t      rs2, rs2_n;
    reg_id_t      rs3, rs3_n;
    logic         need_rs2, need_rs2_n;
    logic         need_rs3, need_rs3_n;
    logic         data_ready, data_ready_n;
    lane_data_t   rs1_data, rs1_data_n;
    lane_data_t   rs2_data, rs2_data_n;
    lane_data_t   rs3_data, rs3_data_n;

    // Issue beat that arrived while the previous instruction was still busy
    logic         pend_valid;
    wid_t         pend_wid;
    reg_id_t      pend_rs1;
    reg_id_t      pend_rs2;
    reg_id_t      pend_rs3;
    logic         pend_load;

    wid_t         src_wid;
    reg_id_t      src_rs1;
    reg_id_t      src_rs2;
    reg_id_t      src_rs3;
    logic         src_valid;
    logic         nz1;
    logic         nz2;
    logic         nz3;
    logic         stg_fire;
    logic         start;

    // The held beat is always older than one on the issue port
    assign src_wid   = pend_valid ? pend_wid : issue.wid;
    assign src_rs1   = pend_valid ? pend_rs1 : issue.rs1;
    assign src_rs2   = pend_valid ? pend_rs2 : issue.rs2;
    assign src_rs3   = pend_valid ? pend_rs3 : issue.rs3;
    assign src_valid = pend_valid || issue_fire;

    assign nz1 = (src_rs1 != '0);
    assign nz2 = (src_rs2 != '0);
    assign nz3 = (src_rs3 != '0);

    // The staging head is released only once its operands are all captured
    assign out_valid = stg_valid && data_ready;
    assign stg_ready = out_ready && data_ready;
    assign stg_fire  = stg_valid && data_ready && out_ready;

    // A new instruction may start in the cycle the finished one leaves
    assign start     = src_valid && (state == idle) && (!data_ready || stg_fire);
    assign pend_load = issue_fire && (pend_valid || !start);

    always_comb begin
        state_n      = state;
        cur_wid_n    = cur_wid;
        rs2_n        = rs2;
        rs3_n        = rs3;
        need_rs2_n   = need_rs2;
        need_rs3_n   = need_rs3;
        data_ready_n = data_ready;
        rs1_data_n   = rs1_data;
        rs2_data_n   = rs2_data;
        rs3_data_n   = rs3_data;
        rd_wid       = cur_wid;
        rd_reg       = rs3;

        case (state)
            idle: begin
                if (stg_fire) begin
                    data_ready_n = 1'b0;
                end
                if (start) begin
                    cur_wid_n    = src_wid;
                    rs2_n        = src_rs2;
                    rs3_n        = src_rs3;
                    need_rs2_n   = nz2;
                    need_rs3_n   = nz3;
                    data_ready_n = !(nz1 || nz2 || nz3);
                    rd_wid       = src_wid;
                    // First read goes out with the issue beat itself
                    rd_reg       = nz1 ? src_rs1 : (nz2 ? src_rs2 : src_rs3);
                    if (!nz1) begin
                        rs1_data_n = '0;
                    end
                    if (!nz2) begin
                        rs2_data_n = '0;
                    end
                    if (!nz3) begin
                        rs3_data_n = '0;
                    end
                    if (nz1) begin
                        state_n = fetch_rs1;
                    end else if (nz2) begin
                        state_n = fetch_rs2;
                    end else if (nz3) begin
                        state_n = fetch_rs3;
                    end
                end
            end
            fetch_rs1: begin
                rs1_data_n = rd_data;
                if (need_rs2) begin
                    rd_reg  = rs2;
                    state_n = fetch_rs2;
                end else if (need_rs3) begin
                    rd_reg  = rs3;
                    state_n = fetch_rs3;
                end else begin
                    data_ready_n = 1'b1;
                    state_n      = idle;
                end
            end
            fetch_rs2: begin
                rs2_data_n = rd_data;
                if (need_rs3) begin
                    rd_reg  = rs3;
                    state_n = fetch_rs3;
                end else begin
                    data_ready_n = 1'b1;
                    state_n      = idle;
                end
            end
            default: begin
                rs3_data_n   = rd_data;
                data_ready_n = 1'b1;
                state_n      = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state      <= idle;
            need_rs2   <= 1'b0;
            need_rs3   <= 1'b0;
            data_ready <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            state      <= state_n;
            need_rs2   <= need_rs2_n;
            need_rs3   <= need_rs3_n;
            data_ready <= data_ready_n;
            if (pend_load) begin
                pend_valid <= 1'b1;
            end else if (start) begin
                pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        cur_wid  <= cur_wid_n;
        rs2      <= rs2_n;
        rs3      <= rs3_n;
        rs1_data <= rs1_data_n;
        rs2_data <= rs2_data_n;
        rs3_data <= rs3_data_n;
        if (pend_load) begin
            pend_wid <= issue.wid;
            pend_rs1 <= issue.rs1;
            pend_rs2 <= issue.rs2;
            pend_rs3 <= issue.rs3;
        end
    end

    assign out = '{instr: stg, rs1_data: rs1_data, rs2_data: rs2_data, rs3_data: rs3_data};

endmodule

//--- run.sh
#!/bin/sh
# Compile with Verilator, run the simulation and look for the pass message in the log
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module opc_tb -o opc_sim \
    && ./obj_dir/opc_sim +verilator+error+limit+100 2>&1 | tee sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1

//--- test/opc_asserts.sv
`timescale 1ns/1ps
//**************************************************************************
// Operand collection stage assertions
// Checks the issue and output handshakes and the state after reset and
// flush. Bound to the top level of the stage
//**************************************************************************
module opc_asserts (
    input logic               clk,
    input logic               reset,
    input logic               flush,
    input logic               issue_valid,
    input logic               issue_ready,
    input opc_pkg::issue_t    issue,
    input logic               out_valid,
    input logic               out_ready,
    input opc_pkg::operands_t out
);
    int   out_hold_fails;
    int   issue_hold_fails;
    int   idle_fails;
    int   reset_fails;
    int   flush_fails;
    int   failures;
    logic seen_issue;

    assign failures = out_hold_fails + issue_hold_fails + idle_fails + reset_fails + flush_fails;

    // Set by the first accepted issue beat after reset
    always @(posedge clk) begin
        if (reset) begin
            seen_issue <= 1'b0;
        end else if (issue_valid && issue_ready) begin
            seen_issue <= 1'b1;
        end
    end

    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out))
        else begin
            $error("Output beat changed or dropped while the stream was stalled");
            out_hold_fails++;
        end

    issue_hold: assert property (@(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue))
        else begin
            $error("Issue beat changed or dropped while the stream was stalled");
            issue_hold_fails++;
        end

    quiet_until_issue: assert property (@(posedge clk) disable iff (reset)
        !seen_issue |-> !out_valid)
        else begin
            $error("Output valid before any instruction was issued");
            idle_fails++;
        end

    ready_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> issue_ready && !out_valid)
        else begin
            $error("Stage not empty and ready in the first cycle after reset");
            reset_fails++;
        end

    flush_empties: assert property (@(posedge clk) disable iff (reset)
        flush |=> !out_valid)
        else begin
            $error("Output valid in the cycle after a flush");
            flush_fails++;
        end

endmodule

bind opc_top opc_asserts asserts (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue       (issue),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out         (out)
);

//--- test/opc_checker.sv
`timescale 1ns/1ps
//**************************************************************************
// Operand collection stage checker
// Keeps a shadow register file, queues the expected operands of every
// accepted instruction and compares each output beat with the oldest one
//**************************************************************************
module opc_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                issue_valid,
    input  logic                issue_ready,
    input  opc_pkg::issue_t     issue,
    input  logic                wb_valid,
    input  opc_pkg::writeback_t wb,
    input  logic                out_valid,
    input  logic                out_ready,
    input  opc_pkg::operands_t  out,
    output int                  pending,
    output int                  errors,
    output int                  compared
);
    import opc_pkg::*;

    lane_data_t shadow [num_warps][num_regs];
    operands_t  exp_q [$];

    // Register zero always reads as zero
    function automatic lane_data_t read_source(input wid_t wid, input reg_id_t src);
        return (src == '0) ? '0 : shadow[wid][src];
    endfunction

    function automatic operands_t expected_operands(input issue_t req);
        operands_t e;
        e.instr = '{uuid: req.uuid, wid: req.wid, tmask: req.tmask, pc: req.pc,
                    op: req.op, imm: req.imm, rd: req.rd, wb: req.wb};
        e.rs1_data = read_source(req.wid, req.rs1);
        e.rs2_data = read_source(req.wid, req.rs2);
        e.rs3_data = read_source(req.wid, req.rs3);
        return e;
    endfunction

    task automatic check_lanes(input string name, input lane_data_t expected,
                               input lane_data_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_output();
        operands_t e;
        if (exp_q.size() == 0) begin
            $display("Output beat with uuid %h arrived with no instruction outstanding",
                     out.instr.uuid);
            errors++;
        end else begin
            e = exp_q.pop_front();
            compared++;
            if (out.instr !== e.instr) begin
                $display("Error: out.instr expected %h actual %h", e.instr, out.instr);
                errors++;
            end
            check_lanes("out.rs1_data", e.rs1_data, out.rs1_data);
            check_lanes("out.rs2_data", e.rs2_data, out.rs2_data);
            check_lanes("out.rs3_data", e.rs3_data, out.rs3_data);
        end
    endtask

    // Operands are taken before this cycle's writeback, which lands at the same edge
    always @(posedge clk) begin
        if (reset) begin
            exp_q.delete();
        end else begin
            if (out_valid && out_ready) begin
                compare_output();
            end
            if (issue_valid && issue_ready) begin
                exp_q.push_back(expected_operands(issue));
            end
            if (wb_valid) begin
                for (int t = 0; t < num_threads; t++) begin
                    if (wb.tmask[t]) begin
                        shadow[wb.wid][wb.rd][t] = wb.data[t];
                    end
                end
            end
            if (flush) begin
                exp_q.delete();
            end
        end
        pending = exp_q.size();
    end

endmodule

//--- test/opc_tb.sv
`timescale 1ns/1ps
//**************************************************************************
// Operand collection stage testbench
// Applies a table of writeback, issue, flush and drain rows to the DUT
// with random output back-pressure, then reports the error counts
//**************************************************************************
module opc_tb;
    import opc_pkg::*;

    typedef enum logic [1:0] {
        row_wb,
        row_issue,
        row_flush,
        row_drain
    } row_kind_e;

    // The fields in use depend on the kind of row
    typedef struct packed {
        row_kind_e  kind;
        wid_t       wid;
        reg_id_t    rd;
        tmask_t     tmask;
        reg_id_t    rs1;
        reg_id_t    rs2;
        reg_id_t    rs3;
        logic [7:0] ready_pct;
    } row_t;

    localparam int issue_limit = 1000;
    localparam int drain_limit = 4000;

    logic        clk = 1'b0;
    logic        reset;
    logic        flush;
    logic        issue_valid;
    logic        issue_ready;
    issue_t      issue;
    logic        wb_valid;
    writeback_t  wb;
    logic        out_valid;
    logic        out_ready = 1'b0;
    operands_t   out;
    logic [31:0] ready_pct = 32'd100;
    row_t        rows [$];
    uuid_t       next_uuid;
    int          pending;
    int          data_errors;
    int          compared;
    int          run_errors;
    int          assert_fails;

    opc_top UUT (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out         (out)
    );

    opc_checker chk (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out         (out),
        .pending     (pending),
        .errors      (data_errors),
        .compared    (compared)
    );

    assign assert_fails = UUT.asserts.failures;

    always #5 clk = ~clk;

    // Back-pressure follows the percentage of the current row
    always @(negedge clk) begin
        out_ready = ($urandom_range(99) < ready_pct);
    end

    function automatic void add_wb(input wid_t wid, input reg_id_t rd, input tmask_t tmask);
        rows.push_back('{row_wb, wid, rd, tmask, '0, '0, '0, 8'd100});
    endfunction

    function automatic void add_issue(input wid_t wid, input reg_id_t rs1, input reg_id_t rs2,
                                      input reg_id_t rs3, input logic [7:0] pct);
        rows.push_back('{row_issue, wid, '0, '0, rs1, rs2, rs3, pct});
    endfunction

    function automatic void add_control(input row_kind_e kind, input logic [7:0] pct);
        rows.push_back('{kind, '0, '0, '0, '0, '0, '0, pct});
    endfunction

    function automatic reg_id_t random_reg();
        return ($urandom_range(3) == 0) ? '0 : reg_id_t'($urandom_range(31));
    endfunction

    task automatic build_table();
        // Every register of every warp holds a known value first
        for (int w = 0; w < num_warps; w++) begin
            for (int r = 1; r < num_regs; r++) begin
                add_wb(wid_t'(w), reg_id_t'(r), '1);
            end
        end
        for (int w = 0; w < num_warps; w++) begin
            add_wb(wid_t'(w), reg_id_t'(4 + w), (w % 2 == 0) ? 4'b0101 : 4'b1010);
            add_wb(wid_t'(w), reg_id_t'(20 + w), tmask_t'(1 << w));
        end
        for (int w = 0; w < num_warps; w++) begin
            add_issue(wid_t'(w), reg_id_t'(4 + w), reg_id_t'(20 + w), '0, 8'd100);
        end
        add_control(row_drain, 8'd100);
        // Zero, one, two and three live sources
        add_issue(2'd0, 5'd0, 5'd0, 5'd0, 8'd100);
        add_issue(2'd1, 5'd0, 5'd7, 5'd0, 8'd100);
        add_issue(2'd2, 5'd0, 5'd0, 5'd9, 8'd100);
        add_issue(2'd3, 5'd3, 5'd0, 5'd0, 8'd100);
        add_issue(2'd0, 5'd0, 5'd5, 5'd6, 8'd100);
        add_issue(2'd1, 5'd8, 5'd9, 5'd10, 8'd100);
        add_issue(2'd2, 5'd31, 5'd0, 5'd31, 8'd100);
        add_control(row_drain, 8'd100);
        for (int n = 0; n < 40; n++) begin
            add_issue(wid_t'($urandom_range(3)), random_reg(), random_reg(), random_reg(), 8'd20);
        end
        add_control(row_drain, 8'd100);
        // Each write lands in the cycle before the read of the same register
        for (int w = 0; w < num_warps; w++) begin
            add_wb(wid_t'(w), 5'd12, '1);
            add_issue(wid_t'(w), 5'd12, 5'd0, 5'd12, 8'd100);
        end
        add_control(row_drain, 8'd100);
        for (int n = 0; n < 3; n++) begin
            add_issue(wid_t'(n), 5'd1, reg_id_t'(n + 2), 5'd0, 8'd0);
        end
        add_control(row_flush, 8'd0);
        add_issue(2'd3, 5'd1, 5'd2, 5'd3, 8'd100);
        add_issue(2'd0, 5'd0, 5'd4, 5'd0, 8'd100);
        add_control(row_drain, 8'd100);
    endtask

    task automatic drive_wb(input row_t r);
        wb.wid   = r.wid;
        wb.rd    = r.rd;
        wb.tmask = r.tmask;
        for (int t = 0; t < num_threads; t++) begin
            wb.data[t] = $urandom;
        end
        wb_valid = 1'b1;
        @(posedge clk);
    endtask

    task automatic drive_issue(input row_t r);
        int waited;
        issue.uuid  = next_uuid;
        issue.wid   = r.wid;
        issue.tmask = tmask_t'($urandom_range(1, 15));
        issue.pc    = $urandom;
        issue.op    = op_t'($urandom);
        issue.imm   = $urandom;
        issue.rd    = reg_id_t'($urandom);
        issue.wb    = 1'($urandom);
        issue.rs1   = r.rs1;
        issue.rs2   = r.rs2;
        issue.rs3   = r.rs3;
        issue_valid = 1'b1;
        next_uuid   = next_uuid + 1'b1;
        waited      = 0;
        @(posedge clk);
        while (!issue_ready && waited < issue_limit) begin
            @(posedge clk);
            waited++;
        end
        if (!issue_ready) begin
            $display("Issue uuid %h was not accepted within %0d cycles", issue.uuid, issue_limit);
            run_errors++;
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (pending != 0 && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("Output stream did not drain within %0d cycles", drain_limit);
            run_errors++;
        end
    endtask

    initial begin
        void'($urandom(32'h61c6_13f4));
        reset       = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        wb_valid    = 1'b0;
        wb          = '0;
        next_uuid   = '0;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            ready_pct <= 32'(rows[i].ready_pct);
            @(negedge clk);
            issue_valid = 1'b0;
            wb_valid    = 1'b0;
            flush       = 1'b0;
            case (rows[i].kind)
                row_wb:    drive_wb(rows[i]);
                row_issue: drive_issue(rows[i]);
                row_flush: begin
                    flush = 1'b1;
                    @(posedge clk);
                end
                default:   drain_outputs();
            endcase
        end
        @(negedge clk);
        issue_valid = 1'b0;
        wb_valid    = 1'b0;
        flush       = 1'b0;
        drain_outputs();
        if (pending != 0) begin
            $display("%0d expected output beats never appeared", pending);
            run_errors++;
        end
        $display("Compared %0d outputs: %0d data errors, %0d assertion failures, %0d run errors",
                 compared, data_errors, assert_fails, run_errors);
        if (data_errors + assert_fails + run_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
design/opc_pkg.sv
design/gpr_file.sv
design/elastic_buffer.sv
design/operand_collector.sv
design/opc_top.sv
test/opc_asserts.sv
test/opc_checker.sv
test/opc_tb.sv
